// ==== cpu_ctrl_consts.svh ====
`ifndef CPU_CTRL_CONSTS_SVH
`define CPU_CTRL_CONSTS_SVH

// ----------------------------------------------------------------------
// Major opcodes
// ----------------------------------------------------------------------
`define OPC_LOAD        7'b0000011
`define OPC_OP_IMM      7'b0010011
`define OPC_JALR        7'b1100111
`define OPC_OP_IMM_W    7'b0011011
`define OPC_STORE       7'b0100011
`define OPC_OP          7'b0110011
`define OPC_OP_W        7'b0111011
`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111
`define OPC_AUIPC       7'b0010111
`define OPC_LUI         7'b0110111
`define OPC_SYSTEM      7'b1110011

`define MCAUSE_INSTR_MA  4'd0
`define MCAUSE_ILLEGAL   4'd2
`define MCAUSE_BREAK     4'd3
`define MCAUSE_SW_INT    4'd3   // Shares code 3, told apart by interrupt bit.
`define MCAUSE_LOAD_MA   4'd4
`define MCAUSE_STORE_MA  4'd6
`define MCAUSE_TIMER_INT 4'd7
`define MCAUSE_ECALL_M   4'd11

`define CSR_IDX_MHARTID 3'd1
`define CSR_IDX_MTVEC   3'd3
`define CSR_IDX_MCAUSE  3'd4
`define CSR_IDX_MEPC    3'd5

// ----------------------------------------------------------------------
// Datapath mux selects and ALU ops
// ----------------------------------------------------------------------
`define RES_ALU_REG   3'd0
`define RES_MEM       3'd1
`define RES_ALU_OUT   3'd2
`define RES_IMM       3'd3
`define RES_CSR_DATA  3'd4
`define RES_CSR_REG   3'd5
`define RES_OLD_PC    3'd6
`define RES_TRAP_ADDR 3'd7

`define SRC1_PC     2'd0
`define SRC1_OLD_PC 2'd1
`define SRC1_RS1    2'd2
`define SRC1_ZIMM   2'd3
`define SRC2_RS2    2'd0
`define SRC2_IMM    2'd1
`define SRC2_FOUR   2'd2
`define SRC2_CSR    2'd3

`define ALU_ADD    3'd0
`define ALU_BRANCH 3'd1
`define ALU_FUNC   3'd2
`define ALU_FUNC_W 3'd3
`define ALU_CSR    3'd4

`endif

// ==== cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

    // ----------------------------------------------------------------------
    // Sequencer states and instruction classes
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        st_fetch      = 4'd0,
        st_decode     = 4'd1,
        st_mem_addr   = 4'd2,
        st_mem_read   = 4'd3,
        st_mem_wb     = 4'd4,
        st_mem_write  = 4'd5,
        st_exec_r     = 4'd6,
        st_alu_wb     = 4'd7,
        st_exec_i     = 4'd8,
        st_jump       = 4'd9,
        st_branch     = 4'd10,
        st_load_imm   = 4'd11,
        st_trap_enter = 4'd12,
        st_csr_exec   = 4'd13,
        st_csr_wb     = 4'd14
    } ctrl_state_t;

    typedef enum logic [3:0] {
        cls_load     = 4'd0,
        cls_op_imm   = 4'd1,
        cls_jalr     = 4'd2,
        cls_op_imm_w = 4'd3,
        cls_store    = 4'd4,
        cls_op       = 4'd5,
        cls_op_w     = 4'd6,
        cls_branch   = 4'd7,
        cls_jal      = 4'd8,
        cls_auipc    = 4'd9,
        cls_lui      = 4'd10,
        cls_system   = 4'd11,
        cls_illegal  = 4'd12
    } instr_class_t;

    typedef struct packed {
        instr_class_t cls;
        logic         csr_op;       // Nonzero func3.
        logic         mret;
        logic         brk;          // EBREAK versus ECALL.
        logic         word_illegal;
        logic         mhartid_sel;
        logic         csr_zimm;
        logic [2:0]   csr_idx;
    } decoded_t;

    typedef struct packed {
        logic stall_instr;
        logic stall_data;
        logic instr_addr_ma;
        logic load_addr_ma;
        logic store_addr_ma;
        logic illegal_load;
        logic illegal_alu;
        logic timer_int;
        logic software_int;
        logic icache_idle;
    } core_status_t;

    typedef struct packed {
        logic       take;
        logic       interrupt;
        logic [3:0] mcause;
    } trap_t;

    typedef struct packed {
        logic [2:0] alu_op;
        logic [1:0] alu_src_1;
        logic [1:0] alu_src_2;
        logic [2:0] result_src;
        logic       reg_write_en;
        logic       pc_update;
        logic       instr_write_en;
        logic       branch;
        logic       mem_reg_we;
        logic       reg_mem_addr_we;
        logic       mem_write_en;
        logic       start_i_cache;
        logic       start_d_cache;
        logic       fetch_state;
    } dp_ctrl_t;

    typedef struct packed {
        logic       csr_we_1;
        logic       csr_we_2;
        logic       csr_reg_we;
        logic [2:0] write_addr_1;
        logic [2:0] write_addr_2;
        logic [2:0] read_addr;
        logic [3:0] mcause;
        logic       interrupt;
        logic       mret;
    } csr_ctrl_t;

endpackage

// ==== instr_decoder.sv ====
`timescale 1ns/1ps
`include "cpu_ctrl_consts.svh"

module instr_decoder (
    input  logic [31:0]            i_instr,
    output cpu_ctrl_pkg::decoded_t o_dec
);
    import cpu_ctrl_pkg::*;

    logic [6:0]   opcode;
    logic [2:0]   func3;
    logic [6:0]   func7;
    instr_class_t cls;

    assign opcode = i_instr[6:0];
    assign func3  = i_instr[14:12];
    assign func7  = i_instr[31:25];

    always_comb begin
        case (opcode)
            `OPC_LOAD:     cls = cls_load;
            `OPC_OP_IMM:   cls = cls_op_imm;
            `OPC_JALR:     cls = cls_jalr;
            `OPC_OP_IMM_W: cls = cls_op_imm_w;
            `OPC_STORE:    cls = cls_store;
            `OPC_OP:       cls = cls_op;
            `OPC_OP_W:     cls = cls_op_w;
            `OPC_BRANCH:   cls = cls_branch;
            `OPC_JAL:      cls = cls_jal;
            `OPC_AUIPC:    cls = cls_auipc;
            `OPC_LUI:      cls = cls_lui;
            `OPC_SYSTEM:   cls = cls_system;
            default:       cls = cls_illegal; // FENCE lands here as well.
        endcase
    end

    always_comb begin
        o_dec.cls          = cls;
        o_dec.csr_op       = |func3;
        // MRET is the only SYSTEM word with func3 zero and bit 29 set.
        o_dec.mret         = (cls == cls_system) && (func3 == 3'b000) && func7[4];
        o_dec.brk          = i_instr[20];
        o_dec.word_illegal = func7[0] && ((cls == cls_op) || (cls == cls_op_w)); // No M ext.
        o_dec.mhartid_sel  = func7[6];
        o_dec.csr_zimm     = func3[2];
        o_dec.csr_idx      = {i_instr[26], i_instr[22], i_instr[20]};
    end

endmodule

// ==== trap_encoder.sv ====
`timescale 1ns/1ps
`include "cpu_ctrl_consts.svh"

module trap_encoder (
    input  cpu_ctrl_pkg::ctrl_state_t  i_state,
    input  cpu_ctrl_pkg::decoded_t     i_dec,
    input  cpu_ctrl_pkg::core_status_t i_status,
    output cpu_ctrl_pkg::trap_t        o_trap
);
    import cpu_ctrl_pkg::*;

    logic any_int;
    logic env_call;

    assign any_int  = i_status.timer_int || i_status.software_int;
    assign env_call = (i_dec.cls == cls_system) && !i_dec.csr_op && !i_dec.mret;

    always_comb begin
        o_trap = '0;
        case (i_state)
            st_fetch: begin
                if (i_status.icache_idle && any_int) begin
                    o_trap.take      = 1'b1;
                    o_trap.interrupt = 1'b1;
                    o_trap.mcause    = i_status.timer_int ? `MCAUSE_TIMER_INT
                                                          : `MCAUSE_SW_INT;
                end else if (i_status.icache_idle && i_status.instr_addr_ma) begin
                    o_trap.take   = 1'b1;
                    o_trap.mcause = `MCAUSE_INSTR_MA;
                end
            end
            st_decode: begin
                if (i_dec.cls == cls_illegal) begin
                    o_trap.take   = 1'b1;
                    o_trap.mcause = `MCAUSE_ILLEGAL;
                end else if (env_call) begin
                    o_trap.take   = 1'b1;
                    o_trap.mcause = i_dec.brk ? `MCAUSE_BREAK : `MCAUSE_ECALL_M;
                end
            end
            st_mem_read: begin
                o_trap.take   = i_status.illegal_load || i_status.load_addr_ma;
                o_trap.mcause = i_status.illegal_load ? `MCAUSE_ILLEGAL : `MCAUSE_LOAD_MA;
            end
            st_mem_write: begin
                o_trap.take   = i_status.store_addr_ma;
                o_trap.mcause = `MCAUSE_STORE_MA;
            end
            st_alu_wb: begin
                o_trap.take   = i_status.illegal_alu || i_dec.word_illegal;
                o_trap.mcause = `MCAUSE_ILLEGAL;
            end
            st_csr_exec: begin
                o_trap.take   = i_status.illegal_alu;
                o_trap.mcause = `MCAUSE_ILLEGAL;
            end
            default: o_trap = '0;
        endcase
    end

endmodule

// ==== ctrl_sequencer.sv ====
`timescale 1ns/1ps

module ctrl_sequencer (
    input  logic                       clk,
    input  logic                       arst,
    input  cpu_ctrl_pkg::decoded_t     i_dec,
    input  cpu_ctrl_pkg::core_status_t i_status,
    input  cpu_ctrl_pkg::trap_t        i_trap,
    output cpu_ctrl_pkg::ctrl_state_t  o_state
);
    import cpu_ctrl_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    ctrl_state_t decode_next;

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            state_q <= st_fetch;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------------------------------------
    // Dispatch out of decode
    // ----------------------------------------------------------------------
    always_comb begin
        case (i_dec.cls)
            cls_load, cls_store, cls_jalr: decode_next = st_mem_addr;
            cls_op_imm, cls_op_imm_w:      decode_next = st_exec_i;
            cls_op, cls_op_w:              decode_next = st_exec_r;
            cls_branch:                    decode_next = st_branch;
            cls_jal:                       decode_next = st_jump;
            cls_auipc:                     decode_next = st_alu_wb; // Sum made in decode.
            cls_lui:                       decode_next = st_load_imm;
            cls_system: begin
                if (i_dec.csr_op) begin
                    decode_next = st_csr_exec;
                end else if (i_dec.mret) begin
                    decode_next = st_jump;
                end else begin
                    decode_next = st_trap_enter;
                end
            end
            default:                       decode_next = st_trap_enter;
        endcase
    end

    always_comb begin
        state_d = st_fetch;
        case (state_q)
            st_fetch:     state_d = i_status.stall_instr ? st_fetch : st_decode;
            st_decode:    state_d = decode_next;
            st_mem_addr: begin
                case (i_dec.cls)
                    cls_load:  state_d = st_mem_read;
                    cls_store: state_d = st_mem_write;
                    cls_jalr:  state_d = st_jump;
                    default:   state_d = st_fetch;
                endcase
            end
            st_mem_read:  state_d = i_status.stall_data ? st_mem_read : st_mem_wb;
            st_mem_write: state_d = i_status.stall_data ? st_mem_write : st_fetch;
            st_exec_r:    state_d = st_alu_wb;
            st_exec_i:    state_d = st_alu_wb;
            st_jump:      state_d = i_dec.mret ? st_fetch : st_alu_wb;
            st_csr_exec:  state_d = st_csr_wb;
            default:      state_d = st_fetch;
        endcase

        if (i_trap.take) begin
            state_d = st_trap_enter;
        end
    end

    assign o_state = state_q;

    a_no_unused_state: assert property (@(posedge clk) disable iff (arst)
        state_q != 4'hf)
        else $error("sequencer reached the unused state code");

    a_trap_state: assert property (@(posedge clk) disable iff (arst)
        i_trap.take |-> state_q inside {st_fetch, st_decode, st_mem_read, st_mem_write,
                                         st_alu_wb, st_csr_exec})
        else $error("trap taken in a state without a trap rule");

endmodule

// ==== datapath_ctrl.sv ====
`timescale 1ns/1ps
`include "cpu_ctrl_consts.svh"

module datapath_ctrl (
    input  cpu_ctrl_pkg::ctrl_state_t  i_state,
    input  cpu_ctrl_pkg::decoded_t     i_dec,
    input  cpu_ctrl_pkg::core_status_t i_status,
    input  cpu_ctrl_pkg::trap_t        i_trap,
    output cpu_ctrl_pkg::dp_ctrl_t     o_dp_ctrl,
    output cpu_ctrl_pkg::csr_ctrl_t    o_csr_ctrl
);
    import cpu_ctrl_pkg::*;

    logic [2:0] csr_sel;
    logic       word_op;

    assign csr_sel = i_dec.mhartid_sel ? `CSR_IDX_MHARTID : i_dec.csr_idx;
    assign word_op = (i_dec.cls == cls_op_w) || (i_dec.cls == cls_op_imm_w);

    always_comb begin
        o_dp_ctrl               = '0;
        o_csr_ctrl              = '0;
        o_csr_ctrl.write_addr_1 = csr_sel;
        o_csr_ctrl.write_addr_2 = csr_sel;
        o_csr_ctrl.read_addr    = csr_sel;

        case (i_state)
            st_fetch: begin
                o_dp_ctrl.fetch_state    = 1'b1;
                o_dp_ctrl.start_i_cache  = 1'b1;
                o_dp_ctrl.alu_src_1      = `SRC1_PC;
                o_dp_ctrl.alu_src_2      = `SRC2_FOUR;
                o_dp_ctrl.result_src     = `RES_ALU_OUT;
                o_dp_ctrl.pc_update      = !i_status.stall_instr;
                o_dp_ctrl.instr_write_en = !i_status.stall_instr;
            end
            st_decode: begin
                o_dp_ctrl.alu_src_1 = `SRC1_OLD_PC; // Branch and JAL target.
                o_dp_ctrl.alu_src_2 = `SRC2_IMM;
                o_csr_ctrl.mret     = i_dec.mret;
            end
            st_mem_addr: begin
                o_dp_ctrl.alu_src_1       = `SRC1_RS1;
                o_dp_ctrl.alu_src_2       = `SRC2_IMM;
                o_dp_ctrl.result_src      = `RES_ALU_OUT;
                o_dp_ctrl.reg_mem_addr_we = 1'b1;
            end
            st_mem_read: begin
                o_dp_ctrl.start_d_cache = 1'b1;
                o_dp_ctrl.mem_reg_we    = !i_status.stall_data;
            end
            st_mem_wb: begin
                o_dp_ctrl.result_src   = `RES_MEM;
                o_dp_ctrl.reg_write_en = 1'b1;
            end
            st_mem_write: begin
                o_dp_ctrl.start_d_cache = 1'b1;
                o_dp_ctrl.mem_write_en  = !i_status.stall_data;
                o_dp_ctrl.mem_reg_we    = !i_status.stall_data;
            end
            st_exec_r, st_exec_i: begin
                o_dp_ctrl.alu_src_1 = `SRC1_RS1;
                o_dp_ctrl.alu_src_2 = (i_state == st_exec_r) ? `SRC2_RS2 : `SRC2_IMM;
                o_dp_ctrl.alu_op    = word_op ? `ALU_FUNC_W : `ALU_FUNC;
            end
            st_alu_wb: begin
                o_dp_ctrl.result_src   = `RES_ALU_REG;
                o_dp_ctrl.reg_write_en = 1'b1;
            end
            st_jump: begin
                o_dp_ctrl.alu_src_1  = `SRC1_OLD_PC; // Link address.
                o_dp_ctrl.alu_src_2  = `SRC2_FOUR;
                o_dp_ctrl.pc_update  = 1'b1;
                o_dp_ctrl.result_src = i_dec.mret ? `RES_CSR_DATA : `RES_ALU_REG;
                o_csr_ctrl.read_addr = `CSR_IDX_MEPC;
            end
            st_branch: begin
                o_dp_ctrl.alu_src_1 = `SRC1_RS1;
                o_dp_ctrl.alu_src_2 = `SRC2_RS2;
                o_dp_ctrl.alu_op    = `ALU_BRANCH;
                o_dp_ctrl.branch    = 1'b1;
            end
            st_load_imm: begin
                o_dp_ctrl.result_src   = `RES_IMM;
                o_dp_ctrl.reg_write_en = 1'b1;
            end
            st_trap_enter: begin
                o_dp_ctrl.pc_update  = 1'b1;
                o_dp_ctrl.result_src = `RES_TRAP_ADDR;
                o_csr_ctrl.read_addr = `CSR_IDX_MTVEC;
            end
            st_csr_exec: begin
                o_dp_ctrl.alu_src_1   = i_dec.csr_zimm ? `SRC1_ZIMM : `SRC1_RS1;
                o_dp_ctrl.alu_src_2   = `SRC2_CSR;
                o_dp_ctrl.alu_op      = `ALU_CSR;
                o_dp_ctrl.result_src  = `RES_ALU_OUT;
                o_csr_ctrl.csr_we_2   = 1'b1;
                o_csr_ctrl.csr_reg_we = 1'b1; // Old CSR value kept for rd.
            end
            st_csr_wb: begin
                o_dp_ctrl.result_src   = `RES_CSR_REG;
                o_dp_ctrl.reg_write_en = 1'b1;
            end
            default: o_dp_ctrl = '0;
        endcase

        // A trap replaces the state's own writes with the mcause/mepc pair.
        if (i_trap.take) begin
            o_dp_ctrl.reg_write_en   = 1'b0;
            o_dp_ctrl.mem_write_en   = 1'b0;
            o_dp_ctrl.mem_reg_we     = 1'b0;
            o_dp_ctrl.pc_update      = 1'b0;
            o_dp_ctrl.instr_write_en = 1'b0;
            o_dp_ctrl.start_i_cache  = 1'b0;
            o_dp_ctrl.start_d_cache  = 1'b0;
            o_dp_ctrl.result_src     = `RES_OLD_PC;
            o_csr_ctrl.csr_reg_we    = 1'b0;
            o_csr_ctrl.csr_we_1      = 1'b1;
            o_csr_ctrl.csr_we_2      = 1'b1;
            o_csr_ctrl.write_addr_1  = `CSR_IDX_MCAUSE;
            o_csr_ctrl.write_addr_2  = `CSR_IDX_MEPC;
            o_csr_ctrl.mcause        = i_trap.mcause;
            o_csr_ctrl.interrupt     = i_trap.interrupt;
        end
    end

endmodule

// ==== cpu_ctrl_top.sv ====
`timescale 1ns/1ps

module cpu_ctrl_top (
    input  logic                       clk,
    input  logic                       arst,
    input  logic [31:0]                i_instr,
    input  cpu_ctrl_pkg::core_status_t i_status,
    output cpu_ctrl_pkg::dp_ctrl_t     o_dp_ctrl,
    output cpu_ctrl_pkg::csr_ctrl_t    o_csr_ctrl
);
    import cpu_ctrl_pkg::*;

    decoded_t    dec;
    ctrl_state_t state;
    trap_t       trap;

    instr_decoder u_instr_decoder (
        .i_instr (i_instr),
        .o_dec   (dec)
    );

    trap_encoder u_trap_encoder (
        .i_state  (state),
        .i_dec    (dec),
        .i_status (i_status),
        .o_trap   (trap)
    );

    ctrl_sequencer u_ctrl_sequencer (
        .clk      (clk),
        .arst     (arst),
        .i_dec    (dec),
        .i_status (i_status),
        .i_trap   (trap),
        .o_state  (state)
    );

    datapath_ctrl u_datapath_ctrl (
        .i_state    (state),
        .i_dec      (dec),
        .i_status   (i_status),
        .i_trap     (trap),
        .o_dp_ctrl  (o_dp_ctrl),
        .o_csr_ctrl (o_csr_ctrl)
    );

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic arst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        arst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 arst = 1'b0; // Released just after the edge.
    end

endmodule

// ==== tb_cpu_ctrl.sv ====
`timescale 1ns/1ps
`include "cpu_ctrl_consts.svh"

module tb_cpu_ctrl;
    import cpu_ctrl_pkg::*;

    localparam int DRIVE_DLY = 2;
    localparam int WAIT_MAX  = 40;

    localparam logic [1:0] WE_NONE   = 2'd0;
    localparam logic [1:0] WE_REG    = 2'd1;
    localparam logic [1:0] WE_MEM    = 2'd2;
    localparam logic [1:0] WE_BRANCH = 2'd3;

    localparam logic [31:0] I_NOP      = 32'h00000013;
    localparam logic [31:0] I_OP       = 32'h003100B3; // add x1, x2, x3.
    localparam logic [31:0] I_OP_W     = 32'h003100BB;
    localparam logic [31:0] I_OP_IMM   = 32'h00510093; // addi x1, x2, 5.
    localparam logic [31:0] I_OP_IMM_W = 32'h0051009B;
    localparam logic [31:0] I_LOAD     = 32'h00813083; // ld x1, 8(x2).
    localparam logic [31:0] I_STORE    = 32'h00313423; // sd x3, 8(x2).
    localparam logic [31:0] I_BRANCH   = 32'h00310463;
    localparam logic [31:0] I_LUI      = 32'h123450B7;
    localparam logic [31:0] I_JAL      = 32'h010000EF;
    localparam logic [31:0] I_JALR     = 32'h000100E7;
    localparam logic [31:0] I_AUIPC    = 32'h00001097;
    localparam logic [31:0] I_CSR_HART = 32'hF14020F3; // csrrs x1, mhartid, x0.
    localparam logic [31:0] I_MRET     = 32'h30200073;
    localparam logic [31:0] I_ECALL    = 32'h00000073;
    localparam logic [31:0] I_EBREAK   = 32'h00100073;
    localparam logic [31:0] I_FENCE    = 32'h0FF0000F;

    logic         clk;
    logic         arst;
    logic [31:0]  instr;
    core_status_t status;
    dp_ctrl_t     dp;
    csr_ctrl_t    csr;

    // Expectations of the running scenario.
    logic         count_en;
    int           exp_cycles;
    logic [1:0]   exp_we;
    logic         exp_mret;
    logic         trap_en;
    logic [3:0]   exp_mcause;
    logic         exp_int;
    logic         stall_chk_en;
    logic [31:0]  lcg_state;
    int           since_fetch;
    int           we_count;
    logic         we_now;

    tb_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(5)) u_clk_gen (.clk(clk), .arst(arst));

    cpu_ctrl_top dut (
        .clk        (clk),
        .arst       (arst),
        .i_instr    (instr),
        .i_status   (status),
        .o_dp_ctrl  (dp),
        .o_csr_ctrl (csr)
    );

    // ----------------------------------------------------------------------
    // Cycle and write pulse counters, restarted in every fetch cycle
    // ----------------------------------------------------------------------
    always_comb begin
        case (exp_we)
            WE_REG:    we_now = dp.reg_write_en;
            WE_MEM:    we_now = dp.mem_write_en;
            WE_BRANCH: we_now = dp.branch;
            default:   we_now = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            since_fetch <= 0;
            we_count    <= 0;
        end else if (dp.fetch_state) begin
            since_fetch <= 1;
            we_count    <= 0;
        end else begin
            since_fetch <= since_fetch + 1;
            we_count    <= we_count + int'(we_now);
        end
    end

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    a_reset: assert property (@(posedge clk) (arst || $fell(arst)) |->
        dp.fetch_state && !dp.reg_write_en && !dp.mem_write_en
        && !csr.csr_we_1 && !csr.csr_we_2)
        else report_mismatch("outputs not idle around reset");

    a_cycles: assert property (@(posedge clk) disable iff (arst)
        (count_en && $rose(dp.fetch_state)) |-> since_fetch == exp_cycles)
        else report_mismatch($sformatf("took %0d cycles, expected %0d",
                                       $sampled(since_fetch), exp_cycles));

    a_we_pulse: assert property (@(posedge clk) disable iff (arst)
        (count_en && $rose(dp.fetch_state)) |->
        we_count == ((exp_we != WE_NONE) ? 1 : 0) && (exp_we == WE_NONE || $past(we_now)))
        else report_mismatch("write enable not a single pulse before fetch");

    a_no_trap: assert property (@(posedge clk) disable iff (arst)
        !trap_en |-> !csr.csr_we_1 && !csr.interrupt)
        else report_mismatch("trap taken where none was expected");

    a_trap_taken: assert property (@(posedge clk) disable iff (arst)
        (count_en && trap_en && $rose(dp.fetch_state)) |-> $past(csr.csr_we_1, 2))
        else report_mismatch("expected trap was not taken");

    a_int_taken: assert property (@(posedge clk) disable iff (arst)
        (dp.fetch_state && status.icache_idle && (status.timer_int || status.software_int))
        |-> csr.csr_we_1 && csr.interrupt)
        else report_mismatch("interrupt not taken in an idle fetch");

    a_trap_write: assert property (@(posedge clk) disable iff (arst)
        (trap_en && csr.csr_we_1) |-> csr.csr_we_2
        && csr.write_addr_1 == `CSR_IDX_MCAUSE && csr.write_addr_2 == `CSR_IDX_MEPC
        && csr.mcause == exp_mcause && csr.interrupt == exp_int
        && !dp.start_i_cache && !dp.start_d_cache)
        else report_mismatch("wrong mcause or mepc write on trap");

    a_trap_vector: assert property (@(posedge clk) disable iff (arst)
        (trap_en && $past(csr.csr_we_1)) |-> dp.pc_update && csr.read_addr == `CSR_IDX_MTVEC)
        else report_mismatch("no jump to mtvec after trap");

    a_trap_return: assert property (@(posedge clk) disable iff (arst)
        (trap_en && $past(csr.csr_we_1, 2)) |-> dp.fetch_state)
        else report_mismatch("no fetch after trap entry");

    a_stall_hold: assert property (@(posedge clk) disable iff (arst)
        (dp.start_d_cache && status.stall_data) |-> !dp.mem_reg_we && !dp.mem_write_en)
        else report_mismatch("memory write enable during data stall");

    a_stall_release: assert property (@(posedge clk) disable iff (arst)
        (stall_chk_en && $fell(status.stall_data)) |-> dp.mem_reg_we && !dp.reg_write_en)
        else report_mismatch("load data not latched when stall dropped");

    a_load_wb: assert property (@(posedge clk) disable iff (arst)
        (stall_chk_en && $fell(status.stall_data)) |=>
        dp.reg_write_en && dp.result_src == `RES_MEM)
        else report_mismatch("load writeback not one cycle after stall");

    a_csr_exec: assert property (@(posedge clk) disable iff (arst)
        csr.csr_reg_we |-> csr.csr_we_2 && !csr.csr_we_1
        && csr.write_addr_2 == `CSR_IDX_MHARTID && csr.read_addr == `CSR_IDX_MHARTID)
        else report_mismatch("CSR access not on the mhartid index");

    a_csr_wb: assert property (@(posedge clk) disable iff (arst)
        csr.csr_reg_we |=> dp.reg_write_en && dp.result_src == `RES_CSR_REG)
        else report_mismatch("CSR result not written back");

    a_mret_jump: assert property (@(posedge clk) disable iff (arst)
        csr.mret |=> dp.pc_update && csr.read_addr == `CSR_IDX_MEPC
        && dp.result_src == `RES_CSR_DATA)
        else report_mismatch("MRET did not return through mepc");

    a_mret_seen: assert property (@(posedge clk) disable iff (arst)
        (count_en && exp_mret && $rose(dp.fetch_state)) |-> $past(csr.mret, 2))
        else report_mismatch("mret not raised in decode");

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic report_mismatch(input string msg);
        $display("TEST FAILED");
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("TEST FAILED");
        $fatal(1, "%s at %0t ns", msg, $time);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int rand_below(input int n);
        lcg_state = lcg_next(lcg_state);
        return int'({16'd0, lcg_state[23:8]}) % n;
    endfunction

    task automatic wait_fetch();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
        end while (!dp.fetch_state && n < WAIT_MAX);
        if (!dp.fetch_state) begin
            report_failure("timeout waiting for the fetch state");
        end
    endtask

    task automatic clear_scenario();
        count_en           = 1'b0;
        exp_cycles         = 0;
        exp_we             = WE_NONE;
        exp_mret           = 1'b0;
        trap_en            = 1'b0;
        exp_mcause         = '0;
        exp_int            = 1'b0;
        stall_chk_en       = 1'b0;
        status             = '0;
        status.stall_instr = 1'b1; // Idle in a stalled fetch.
    endtask

    // Called in a stalled fetch cycle.
    task automatic start_instr(input logic [31:0] word, input int cycles, input logic [1:0] we);
        int idle;
        idle = rand_below(3);
        repeat (idle) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        instr              = word;
        exp_cycles         = cycles;
        exp_we             = we;
        count_en           = 1'b1;
        status.stall_instr = 1'b0;
    endtask

    task automatic finish_instr();
        wait_fetch();
        status.stall_instr = 1'b1;
        @(posedge clk); // Count checks sample this edge.
        #DRIVE_DLY;
        clear_scenario();
    endtask

    task automatic run_instr(input logic [31:0] word, input int cycles, input logic [1:0] we);
        start_instr(word, cycles, we);
        finish_instr();
    endtask

    task automatic run_trap(input logic [31:0] word, input int cycles, input logic [3:0] cause);
        trap_en    = 1'b1;
        exp_mcause = cause;
        exp_int    = 1'b0;
        run_instr(word, cycles, WE_NONE);
    endtask

    task automatic run_load_stall();
        int n;
        int k;
        n                 = 1 + rand_below(6);
        stall_chk_en      = 1'b1;
        status.stall_data = 1'b1;
        start_instr(I_LOAD, 5 + n, WE_REG);
        k = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            k++;
        end while (!dp.start_d_cache && k < WAIT_MAX);
        if (!dp.start_d_cache) begin
            report_failure("timeout waiting for the data cache start");
        end
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        status.stall_data = 1'b0;
        finish_instr();
    endtask

    task automatic run_interrupt();
        trap_en             = 1'b1;
        exp_mcause          = `MCAUSE_TIMER_INT; // Timer wins over software.
        exp_int             = 1'b1;
        exp_cycles          = 2;
        exp_we              = WE_NONE;
        count_en            = 1'b1;
        status.timer_int    = 1'b1;
        status.software_int = 1'b1;
        status.icache_idle  = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        status.timer_int    = 1'b0;
        status.software_int = 1'b0;
        status.icache_idle  = 1'b0;
        finish_instr();
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        int n;
        lcg_state = 32'h3408;
        instr     = I_NOP;
        clear_scenario();
        n = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
        end while (arst && n < WAIT_MAX);
        if (arst) begin
            report_failure("reset was never released");
        end

        run_instr(I_OP, 4, WE_REG);
        run_instr(I_OP_W, 4, WE_REG);
        run_instr(I_OP_IMM, 4, WE_REG);
        run_instr(I_OP_IMM_W, 4, WE_REG);
        run_instr(I_LOAD, 5, WE_REG);
        run_instr(I_STORE, 4, WE_MEM);
        run_instr(I_BRANCH, 3, WE_BRANCH);
        run_instr(I_LUI, 3, WE_REG);
        run_instr(I_JAL, 4, WE_REG);
        run_instr(I_JALR, 5, WE_REG);
        run_instr(I_AUIPC, 3, WE_REG);
        run_instr(I_CSR_HART, 4, WE_REG);
        exp_mret = 1'b1;
        run_instr(I_MRET, 3, WE_NONE);

        repeat (3) run_load_stall();

        run_trap(I_FENCE, 3, `MCAUSE_ILLEGAL);
        run_trap(I_ECALL, 3, `MCAUSE_ECALL_M);
        run_trap(I_EBREAK, 3, `MCAUSE_BREAK);
        status.load_addr_ma = 1'b1;
        run_trap(I_LOAD, 5, `MCAUSE_LOAD_MA);
        status.store_addr_ma = 1'b1;
        run_trap(I_STORE, 5, `MCAUSE_STORE_MA);

        run_interrupt();
        // Pending interrupt while the I-cache is busy.
        if (rand_below(2) == 0) begin
            status.timer_int = 1'b1;
        end else begin
            status.software_int = 1'b1;
        end
        run_instr(I_OP, 4, WE_REG);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
cpu_ctrl_pkg.sv
instr_decoder.sv
trap_encoder.sv
ctrl_sequencer.sv
datapath_ctrl.sv
cpu_ctrl_top.sv
tb_clk_gen.sv
tb_cpu_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_ctrl
FILE_LIST ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard *.sv *.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
